/* logic/hart_params.svh */
`ifndef HART_PARAMS_SVH
`define HART_PARAMS_SVH

// first address fetched once reset is released
`define HART_RESET_ADDR 32'h0000_0000

// ebreak ends a program and is reported on the retire port as a halt
`define HART_EBREAK_WORD 32'h0010_0073

// addi x0, x0, 0 is the word a bubble carries down the pipe
`define HART_NOP_WORD 32'h0000_0013

`endif

/* logic/hart_pkg.sv */
package hart_pkg;

  typedef logic [31:0] word_t;     // register and memory data
  typedef logic [31:0] addr_t;     // byte address into imem or dmem
  typedef logic [4:0]  reg_idx_t;  // architectural register number

  // operations the execute stage can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // where the writeback value comes from
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2  // link value of jal
  } wb_sel_e;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    word_t    inst;
    word_t    op_a;        // rs1 data, or zero for lui
    word_t    op_b;        // rs2 data or the immediate
    word_t    store_data;  // rs2 data for sw
    word_t    imm;         // branch and jal offsets come from here
    alu_op_e  alu_op;
    logic     is_branch;
    logic     is_bne;
    logic     is_jal;
    logic     mem_ren;
    logic     mem_wen;
    reg_idx_t rd;
    logic     rd_wen;
    wb_sel_e  wb_sel;
  } id_ex_t;

  typedef struct packed {
    logic     valid;
    addr_t    pc;
    addr_t    next_pc;     // resolved in execute
    word_t    inst;
    word_t    alu_result;  // also the dmem address for lw and sw
    word_t    store_data;
    logic     mem_ren;
    logic     mem_wen;
    reg_idx_t rd;
    logic     rd_wen;
    wb_sel_e  wb_sel;
  } ex_mem_t;

  // load data is not held here since dmem returns it during writeback
  typedef ex_mem_t mem_wb_t;

endpackage

/* logic/hart_fetch.sv */
`timescale 1ns/1ps
`include "hart_params.svh"

module hart_fetch import hart_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_stall,
  input  logic  i_redirect,
  input  addr_t i_redirect_pc,
  output addr_t o_imem_raddr,
  output addr_t o_id_pc,
  output logic  o_id_valid
);

  addr_t pc_q;        // address to request once the pipe moves
  addr_t id_pc_q;     // address of the word imem is returning this cycle
  logic  id_valid_q;  // that word belongs to the program path

  // while stalled the held id address is requested again
  // so the same instruction word is presented to decode next cycle
  assign o_imem_raddr = i_stall ? id_pc_q : pc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q       <= `HART_RESET_ADDR;
      id_valid_q <= 1'b0;
    end else if (i_redirect) begin
      pc_q       <= i_redirect_pc;  // redirect wins over a stall
      id_valid_q <= 1'b0;           // the word in flight is on the wrong path
    end else if (!i_stall) begin
      pc_q       <= pc_q + 32'd4;
      id_valid_q <= 1'b1;
    end
  end

  // the id pc follows the requested address one cycle later, as imem data does
  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      id_pc_q <= o_imem_raddr;
    end
  end

  assign o_id_pc    = id_pc_q;
  assign o_id_valid = id_valid_q;

endmodule

/* logic/hart_decode.sv */
`timescale 1ns/1ps
`include "hart_params.svh"

module hart_decode import hart_pkg::*; (
  input  logic     i_id_valid,
  input  addr_t    i_id_pc,
  input  word_t    i_inst,
  input  word_t    i_rs1_data,
  input  word_t    i_rs2_data,
  output reg_idx_t o_rs1,
  output reg_idx_t o_rs2,
  output logic     o_uses_rs1,
  output logic     o_uses_rs2,
  output id_ex_t   o_id_ex
);

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011  // only ebreak is expected here
  } opcode_e;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       alt;      // bit 30 selects sub and sra
  alu_op_e    func_op;  // alu op named by funct3 for op and op-imm
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign alt    = i_inst[30];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  // every format is sign extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  func_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;  // there is no subi
      3'b001:  func_op = ALU_SLL;
      3'b010:  func_op = ALU_SLT;
      3'b011:  func_op = ALU_SLTU;
      3'b100:  func_op = ALU_XOR;
      3'b101:  func_op = alt ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 in its imm field
      3'b110:  func_op = ALU_OR;
      default: func_op = ALU_AND;
    endcase
  end

  always_comb begin
    o_id_ex            = '0;
    o_id_ex.valid      = i_id_valid;
    o_id_ex.pc         = i_id_pc;
    o_id_ex.inst       = i_id_valid ? i_inst : `HART_NOP_WORD;
    o_id_ex.op_a       = i_rs1_data;
    o_id_ex.op_b       = i_rs2_data;
    o_id_ex.store_data = i_rs2_data;
    o_id_ex.imm        = imm_i;
    o_id_ex.alu_op     = ALU_ADD;  // address and link math all add
    o_id_ex.rd         = i_inst[11:7];
    o_id_ex.wb_sel     = WB_ALU;
    o_uses_rs1         = 1'b0;
    o_uses_rs2         = 1'b0;
    case (opcode)
      OPC_OP: begin
        o_uses_rs1     = 1'b1;
        o_uses_rs2     = 1'b1;
        o_id_ex.alu_op = func_op;
        o_id_ex.rd_wen = 1'b1;
      end
      OPC_OP_IMM: begin
        o_uses_rs1     = 1'b1;
        o_id_ex.op_b   = imm_i;
        o_id_ex.alu_op = func_op;
        o_id_ex.rd_wen = 1'b1;
      end
      OPC_LUI: begin
        o_id_ex.op_a   = '0;  // zero plus the upper immediate
        o_id_ex.op_b   = imm_u;
        o_id_ex.rd_wen = 1'b1;
      end
      OPC_LOAD: begin
        o_uses_rs1      = 1'b1;
        o_id_ex.op_b    = imm_i;
        o_id_ex.mem_ren = 1'b1;
        o_id_ex.rd_wen  = 1'b1;
        o_id_ex.wb_sel  = WB_MEM;
      end
      OPC_STORE: begin
        o_uses_rs1      = 1'b1;
        o_uses_rs2      = 1'b1;  // store data is read as well
        o_id_ex.op_b    = imm_s;
        o_id_ex.mem_wen = 1'b1;
      end
      OPC_BRANCH: begin
        o_uses_rs1        = 1'b1;
        o_uses_rs2        = 1'b1;
        o_id_ex.imm       = imm_b;  // op_b stays rs2 for the compare
        o_id_ex.is_branch = 1'b1;
        o_id_ex.is_bne    = funct3[0];
      end
      OPC_JAL: begin
        o_id_ex.imm    = imm_j;
        o_id_ex.is_jal = 1'b1;
        o_id_ex.rd_wen = 1'b1;
        o_id_ex.wb_sel = WB_PC4;
      end
      default: begin
        o_id_ex.rd = '0;  // ebreak writes nothing and just flows to retire
      end
    endcase
    // a slot with no instruction must not write or redirect
    if (!i_id_valid) begin
      o_id_ex.rd_wen    = 1'b0;
      o_id_ex.mem_ren   = 1'b0;
      o_id_ex.mem_wen   = 1'b0;
      o_id_ex.is_branch = 1'b0;
      o_id_ex.is_jal    = 1'b0;
    end
  end

endmodule

/* logic/hart_regfile.sv */
`timescale 1ns/1ps

module hart_regfile import hart_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  logic     i_wen,
  input  reg_idx_t i_widx,
  input  word_t    i_wdata,
  output word_t    o_rs1_data,
  output word_t    o_rs2_data
);

  word_t regs [1:31];  // x0 has no storage

  // architectural state starts at zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_widx != '0) begin
      regs[i_widx] <= i_wdata;
    end
  end

  // writeback in the same cycle is visible to decode, so WB never causes a stall
  function automatic word_t read_port(input reg_idx_t idx);
    word_t val;
    if (idx == '0) begin
      val = '0;
    end else if (i_wen && i_widx == idx) begin
      val = i_wdata;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule

/* logic/hart_hazard.sv */
`timescale 1ns/1ps

module hart_hazard import hart_pkg::*; (
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  logic     i_uses_rs1,
  input  logic     i_uses_rs2,
  input  logic     i_id_valid,
  input  id_ex_t   i_ex_ctl,   // contents of the ID/EX register
  input  ex_mem_t  i_mem_ctl,  // contents of the EX/MEM register
  output logic     o_stall
);

  logic rs1_busy;  // an older instruction still has to write rs1
  logic rs2_busy;

  // true when a valid producer will write register rs
  function automatic logic writes(input logic valid, input logic wen,
                                  input reg_idx_t rd, input reg_idx_t rs);
    return valid && wen && rd == rs;
  endfunction

  assign rs1_busy = writes(i_ex_ctl.valid, i_ex_ctl.rd_wen, i_ex_ctl.rd, i_rs1) ||
                    writes(i_mem_ctl.valid, i_mem_ctl.rd_wen, i_mem_ctl.rd, i_rs1);
  assign rs2_busy = writes(i_ex_ctl.valid, i_ex_ctl.rd_wen, i_ex_ctl.rd, i_rs2) ||
                    writes(i_mem_ctl.valid, i_mem_ctl.rd_wen, i_mem_ctl.rd, i_rs2);

  // x0 is never pending and an unused field never stalls
  assign o_stall = i_id_valid &&
                   ((i_uses_rs1 && i_rs1 != '0 && rs1_busy) ||
                    (i_uses_rs2 && i_rs2 != '0 && rs2_busy));

endmodule

/* logic/hart_execute.sv */
`timescale 1ns/1ps
`include "hart_params.svh"

module hart_execute import hart_pkg::*; (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_stall,
  input  id_ex_t  i_id_ex,
  output logic    o_redirect,
  output addr_t   o_redirect_pc,
  output id_ex_t  o_ex_ctl,  // the ID/EX register, seen by the hazard unit
  output ex_mem_t o_ex_mem
);

  id_ex_t  id_ex_q;
  ex_mem_t ex_mem_d;
  ex_mem_t ex_mem_q;
  word_t   a;
  word_t   b;
  word_t   alu_res;
  addr_t   pc_plus4;
  addr_t   target;  // pc plus the branch or jal offset
  logic    taken;

  // a stalled or flushed decode slot turns into a bubble
  always_ff @(posedge i_clk) begin
    id_ex_q <= i_id_ex;
    if (i_rst || i_stall || o_redirect) begin
      id_ex_q.valid     <= 1'b0;
      id_ex_q.inst      <= `HART_NOP_WORD;
      id_ex_q.is_branch <= 1'b0;
      id_ex_q.is_jal    <= 1'b0;
      id_ex_q.mem_ren   <= 1'b0;
      id_ex_q.mem_wen   <= 1'b0;
      id_ex_q.rd_wen    <= 1'b0;
    end
  end

  assign a = id_ex_q.op_a;
  assign b = id_ex_q.op_b;

  always_comb begin
    case (id_ex_q.alu_op)
      ALU_ADD:  alu_res = a + b;
      ALU_SUB:  alu_res = a - b;
      ALU_AND:  alu_res = a & b;
      ALU_OR:   alu_res = a | b;
      ALU_XOR:  alu_res = a ^ b;
      ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: alu_res = {31'b0, a < b};
      ALU_SLL:  alu_res = a << b[4:0];  // only the low five bits shift
      ALU_SRL:  alu_res = a >> b[4:0];
      ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
      default:  alu_res = '0;
    endcase
  end

  assign pc_plus4 = id_ex_q.pc + 32'd4;
  assign target   = id_ex_q.pc + id_ex_q.imm;

  // beq is taken on equal and bne on not equal
  assign taken = id_ex_q.valid &&
                 (id_ex_q.is_jal || (id_ex_q.is_branch && ((a == b) != id_ex_q.is_bne)));

  assign o_redirect    = taken;  // flushes fetch and decode at the next edge
  assign o_redirect_pc = target;

  always_comb begin
    ex_mem_d.valid      = id_ex_q.valid;
    ex_mem_d.pc         = id_ex_q.pc;
    ex_mem_d.next_pc    = taken ? target : pc_plus4;
    ex_mem_d.inst       = id_ex_q.inst;
    ex_mem_d.alu_result = alu_res;
    ex_mem_d.store_data = id_ex_q.store_data;
    ex_mem_d.mem_ren    = id_ex_q.mem_ren;
    ex_mem_d.mem_wen    = id_ex_q.mem_wen;
    ex_mem_d.rd         = id_ex_q.rd;
    ex_mem_d.rd_wen     = id_ex_q.rd_wen;
    ex_mem_d.wb_sel     = id_ex_q.wb_sel;
  end

  always_ff @(posedge i_clk) begin
    ex_mem_q <= ex_mem_d;
    if (i_rst) begin
      ex_mem_q.valid   <= 1'b0;
      ex_mem_q.mem_ren <= 1'b0;
      ex_mem_q.mem_wen <= 1'b0;
      ex_mem_q.rd_wen  <= 1'b0;
    end
  end

  assign o_ex_ctl = id_ex_q;
  assign o_ex_mem = ex_mem_q;

endmodule

/* logic/hart_memwb.sv */
`timescale 1ns/1ps
`include "hart_params.svh"

module hart_memwb import hart_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  input  ex_mem_t  i_ex_mem,
  input  word_t    i_dmem_rdata,
  output addr_t    o_dmem_addr,
  output logic     o_dmem_ren,
  output logic     o_dmem_wen,
  output word_t    o_dmem_wdata,
  output logic     o_rf_wen,
  output reg_idx_t o_rf_widx,
  output word_t    o_rf_wdata,
  output logic     o_retire_valid,
  output logic     o_retire_halt,
  output word_t    o_retire_inst,
  output addr_t    o_retire_pc,
  output addr_t    o_retire_next_pc,
  output reg_idx_t o_retire_rd_waddr,
  output word_t    o_retire_rd_wdata
);

  mem_wb_t mem_wb_q;
  word_t   wb_data;

  // word accesses only, the alu already summed base and offset
  assign o_dmem_addr  = i_ex_mem.alu_result;
  assign o_dmem_ren   = i_ex_mem.valid && i_ex_mem.mem_ren;
  assign o_dmem_wen   = i_ex_mem.valid && i_ex_mem.mem_wen;
  assign o_dmem_wdata = i_ex_mem.store_data;

  always_ff @(posedge i_clk) begin
    mem_wb_q <= i_ex_mem;
    if (i_rst) begin
      mem_wb_q.valid  <= 1'b0;
      mem_wb_q.rd_wen <= 1'b0;
    end
  end

  always_comb begin
    case (mem_wb_q.wb_sel)
      WB_MEM:  wb_data = i_dmem_rdata;         // read issued last cycle lands now
      WB_PC4:  wb_data = mem_wb_q.pc + 32'd4;  // jal link address
      default: wb_data = mem_wb_q.alu_result;
    endcase
  end

  // writes to x0 are dropped here so the retire port reports rd as zero
  assign o_rf_wen   = mem_wb_q.valid && mem_wb_q.rd_wen && mem_wb_q.rd != '0;
  assign o_rf_widx  = mem_wb_q.rd;
  assign o_rf_wdata = wb_data;

  assign o_retire_valid    = mem_wb_q.valid;
  assign o_retire_halt     = mem_wb_q.valid && mem_wb_q.inst == `HART_EBREAK_WORD;
  assign o_retire_inst     = mem_wb_q.inst;
  assign o_retire_pc       = mem_wb_q.pc;
  assign o_retire_next_pc  = mem_wb_q.next_pc;
  assign o_retire_rd_waddr = o_rf_wen ? mem_wb_q.rd : '0;
  assign o_retire_rd_wdata = wb_data;

endmodule

/* logic/hart_top.sv */
`timescale 1ns/1ps

module hart_top import hart_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  output addr_t    o_imem_raddr,
  input  word_t    i_imem_rdata,
  output addr_t    o_dmem_addr,
  output logic     o_dmem_ren,
  output logic     o_dmem_wen,
  output word_t    o_dmem_wdata,
  input  word_t    i_dmem_rdata,
  output logic     o_retire_valid,
  output logic     o_retire_halt,
  output word_t    o_retire_inst,
  output addr_t    o_retire_pc,
  output addr_t    o_retire_next_pc,
  output reg_idx_t o_retire_rd_waddr,
  output word_t    o_retire_rd_wdata
);

  logic     stall;
  logic     redirect;
  addr_t    redirect_pc;
  addr_t    id_pc;
  logic     id_valid;
  reg_idx_t rs1;
  reg_idx_t rs2;
  logic     uses_rs1;
  logic     uses_rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  id_ex_t   id_ex;   // decode output heading into ID/EX
  id_ex_t   ex_ctl;  // ID/EX contents for hazard checks
  ex_mem_t  ex_mem;
  logic     rf_wen;
  reg_idx_t rf_widx;
  word_t    rf_wdata;

  hart_fetch u_fetch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_stall       (stall),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_imem_raddr  (o_imem_raddr),
    .o_id_pc       (id_pc),
    .o_id_valid    (id_valid)
  );

  // the instruction word goes straight from imem into decode
  hart_decode u_decode (
    .i_id_valid (id_valid),
    .i_id_pc    (id_pc),
    .i_inst     (i_imem_rdata),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_uses_rs1 (uses_rs1),
    .o_uses_rs2 (uses_rs2),
    .o_id_ex    (id_ex)
  );

  hart_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_wen      (rf_wen),
    .i_widx     (rf_widx),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  hart_hazard u_hazard (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_uses_rs1 (uses_rs1),
    .i_uses_rs2 (uses_rs2),
    .i_id_valid (id_valid),
    .i_ex_ctl   (ex_ctl),
    .i_mem_ctl  (ex_mem),
    .o_stall    (stall)
  );

  hart_execute u_execute (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_stall       (stall),
    .i_id_ex       (id_ex),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_ex_ctl      (ex_ctl),
    .o_ex_mem      (ex_mem)
  );

  hart_memwb u_memwb (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .i_ex_mem          (ex_mem),
    .i_dmem_rdata      (i_dmem_rdata),
    .o_dmem_addr       (o_dmem_addr),
    .o_dmem_ren        (o_dmem_ren),
    .o_dmem_wen        (o_dmem_wen),
    .o_dmem_wdata      (o_dmem_wdata),
    .o_rf_wen          (rf_wen),
    .o_rf_widx         (rf_widx),
    .o_rf_wdata        (rf_wdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_next_pc  (o_retire_next_pc),
    .o_retire_rd_waddr (o_retire_rd_waddr),
    .o_retire_rd_wdata (o_retire_rd_wdata)
  );

endmodule

/* testbench/hart_tb_program.svh */
`ifndef HART_TB_PROGRAM_SVH
`define HART_TB_PROGRAM_SVH

typedef enum logic [2:0] {K_OP, K_OPI, K_LUI, K_LW, K_SW, K_BR, K_JAL, K_BRK} kind_e;

// one program slot in decoded form, which is what the ISA model executes
typedef struct packed {
  kind_e      kind;
  logic [2:0] f3;
  logic       alt;  // sub, sra or srai
  reg_idx_t   rd;   // zero when the instruction writes nothing
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  word_t      imm;
} op_t;

op_t      prog_ops [PROG_LEN + 1];
reg_idx_t recent_rd [3];  // newest destination first

// three picks in four reuse a recent destination so that RAW hazards are frequent
function automatic reg_idx_t pick_src();
  word_t w;
  w = $random(seed);
  if ($unsigned($random(seed)) % 4 != 0) begin
    return recent_rd[$unsigned($random(seed)) % 3];
  end
  return w[4:0];
endfunction

// fills imem with PROG_LEN random instructions and an ebreak, and prog_ops with their meaning
task automatic gen_program();
  op_t   op;
  word_t r;
  word_t s;
  int    tgt;
  recent_rd = '{5'd1, 5'd2, 5'd3};
  for (int i = 0; i < PROG_LEN; i++) begin
    r      = $random(seed);
    s      = $random(seed);
    op     = '0;
    op.rd  = s[4:0];
    op.rs1 = pick_src();
    op.rs2 = pick_src();
    op.f3  = r[14:12];
    op.alt = r[30] && (op.f3 == 3'd0 || op.f3 == 3'd5);
    tgt    = i + 1 + (s[7:5] % 5);  // forward only
    if (tgt > PROG_LEN) begin
      tgt = PROG_LEN;  // the ebreak itself is the furthest target
    end
    case ($unsigned($random(seed)) % 9)
      0, 1: begin
        op.kind = K_OP;
        imem[i] = {1'b0, op.alt, 5'b0, op.rs2, op.rs1, op.f3, op.rd, 7'b0110011};
      end
      2, 3: begin
        op.kind = K_OPI;
        op.alt  = op.alt && op.f3 == 3'd5;  // there is no subi
        op.imm  = {{20{r[11]}}, r[11:0]};
        if (op.f3 == 3'd1 || op.f3 == 3'd5) begin
          op.imm = {21'b0, op.alt, 5'b0, r[4:0]};  // shift amount form
        end
        imem[i] = {op.imm[11:0], op.rs1, op.f3, op.rd, 7'b0010011};
      end
      4: begin
        op.kind = K_LUI;
        op.imm  = {r[31:12], 12'b0};
        imem[i] = {op.imm[31:12], op.rd, 7'b0110111};
      end
      5: begin
        op.kind = K_LW;
        op.rs1  = '0;  // x0 base keeps every word address inside dmem
        op.imm  = {24'b0, r[7:2], 2'b00};
        imem[i] = {op.imm[11:0], 5'd0, 3'b010, op.rd, 7'b0000011};
      end
      6: begin
        op.kind = K_SW;
        op.rs1  = '0;
        op.rd   = '0;
        op.imm  = {24'b0, r[7:2], 2'b00};
        imem[i] = {op.imm[11:5], op.rs2, 5'd0, 3'b010, op.imm[4:0], 7'b0100011};
      end
      7: begin
        op.kind = K_BR;
        op.rd   = '0;
        op.f3   = {2'b00, r[0]};  // beq or bne
        op.imm  = (tgt - i) * 4;
        imem[i] = {op.imm[12], op.imm[10:5], op.rs2, op.rs1, op.f3, op.imm[4:1], op.imm[11],
                   7'b1100011};
      end
      default: begin
        op.kind = K_JAL;
        op.imm  = (tgt - i) * 4;
        imem[i] = {op.imm[20], op.imm[10:1], op.imm[11], op.imm[19:12], op.rd, 7'b1101111};
      end
    endcase
    if (op.rd != '0) begin
      recent_rd = '{op.rd, recent_rd[0], recent_rd[1]};
    end
    prog_ops[i] = op;
  end
  op                 = '0;
  op.kind            = K_BRK;
  prog_ops[PROG_LEN] = op;
  imem[PROG_LEN]     = `HART_EBREAK_WORD;
endtask

`endif

/* testbench/hart_tb.sv */
`timescale 1ns/1ps
`include "hart_params.svh"

module hart_tb import hart_pkg::*; ();

  localparam int PROG_LEN = 200;                     // random instructions before the ebreak
  localparam int LIMIT    = 4 * (PROG_LEN + 1) + 40;  // cycles allowed after reset

  // what the ISA model expects on one retire cycle
  typedef struct packed {
    addr_t    pc;
    addr_t    next_pc;
    word_t    inst;
    reg_idx_t rd;  // zero for sw, branches and writes to x0
    word_t    data;
    logic     halt;
  } retire_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } store_t;

  logic     i_clk;
  logic     i_rst;
  addr_t    o_imem_raddr;
  word_t    i_imem_rdata;
  addr_t    o_dmem_addr;
  logic     o_dmem_ren;
  logic     o_dmem_wen;
  word_t    o_dmem_wdata;
  word_t    i_dmem_rdata;
  logic     o_retire_valid;
  logic     o_retire_halt;
  word_t    o_retire_inst;
  addr_t    o_retire_pc;
  addr_t    o_retire_next_pc;
  reg_idx_t o_retire_rd_waddr;
  word_t    o_retire_rd_wdata;

  integer  seed = 53742;
  word_t   imem [256];
  word_t   dmem [64];
  addr_t   imem_addr_q;
  addr_t   dmem_addr_q;
  retire_t exp_ret [$];   // retire records in program order
  store_t  exp_st [$];
  retire_t want;
  store_t  want_st;
  int      model_count;
  int      retired   = 0;
  int      cycles    = 0;
  int      rst_edges = 0;
  int      checks    = 0;
  int      errors    = 0;
  logic    done      = 1'b0;  // the DUT has retired an instruction with halt set

  `include "hart_tb_program.svh"

  hart_top i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // initial data, a function of the full word index
  function automatic word_t fill_word(input int idx);
    return (idx * 32'h9E37_79B9) ^ 32'hC0DE_5A5A;
  endfunction

  function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
    word_t r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];  // sign bit fills from the left
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp_val);
    checks++;
    assert (got === exp_val) else begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp_val);
      errors++;
    end
  endtask

  // runs the program one instruction at a time and records every retire and store
  task automatic run_model();
    word_t   regs_m [32];
    word_t   mem_m [64];
    addr_t   pc;
    addr_t   npc;
    addr_t   ea;
    op_t     op;
    word_t   a;
    word_t   b;
    word_t   val;
    retire_t rec;
    store_t  st;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
      mem_m[i] = fill_word(i);
    end
    pc = `HART_RESET_ADDR;
    do begin
      op  = prog_ops[pc[9:2]];
      a   = regs_m[op.rs1];
      b   = regs_m[op.rs2];
      ea  = a + op.imm;
      npc = pc + 32'd4;
      val = '0;
      case (op.kind)
        K_OP:  val = alu_model(op.f3, op.alt, a, b);
        K_OPI: val = alu_model(op.f3, op.alt, a, op.imm);
        K_LUI: val = op.imm;
        K_LW:  val = mem_m[ea[7:2]];
        K_SW: begin
          st.addr         = ea;
          st.data         = b;
          mem_m[ea[7:2]]  = b;
          exp_st.push_back(st);
        end
        K_BR: begin
          if ((a == b) != op.f3[0]) begin
            npc = pc + op.imm;
          end
        end
        K_JAL: begin
          val = pc + 32'd4;  // link value
          npc = pc + op.imm;
        end
        default: val = '0;
      endcase
      if (op.rd != '0) begin
        regs_m[op.rd] = val;
      end
      rec.pc      = pc;
      rec.next_pc = npc;
      rec.inst    = imem[pc[9:2]];
      rec.rd      = op.rd;
      rec.data    = val;
      rec.halt    = op.kind == K_BRK;
      exp_ret.push_back(rec);
      pc = npc;
    end while (!rec.halt);
  endtask

  // both memories register the address at the rising edge and answer at the falling edge
  always @(posedge i_clk) begin
    imem_addr_q <= o_imem_raddr;
    if (o_dmem_ren === 1'b1) begin
      dmem_addr_q <= o_dmem_addr;
    end
    if (o_dmem_wen === 1'b1) begin
      dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;  // a write lands at this edge
    end
  end

  always @(negedge i_clk) begin
    i_imem_rdata <= imem[imem_addr_q[9:2]];
    i_dmem_rdata <= dmem[dmem_addr_q[7:2]];
  end

  // outputs are sampled at the rising edge, before the DUT registers update
  always @(posedge i_clk) begin
    if (i_rst) begin
      if (rst_edges > 0) begin
        assert (o_retire_valid === 1'b0 && o_dmem_ren === 1'b0 && o_dmem_wen === 1'b0) else begin
          $display("retire valid or a dmem enable is high during reset");
          errors++;
        end
      end
      rst_edges++;
    end else if (!done) begin
      cycles++;
      if (retired == 0) begin
        // only the very first instruction can use dmem before anything retires
        assert ((o_dmem_ren === 1'b0 && o_dmem_wen === 1'b0) ||
                prog_ops[0].kind == K_LW || prog_ops[0].kind == K_SW) else begin
          $display("dmem enable is high before any instruction reached the MEM stage");
          errors++;
        end
      end
      assert (!(o_dmem_ren && o_dmem_wen)) else begin
        $display("dmem read and write enables are high in the same cycle");
        errors++;
      end
      if (o_dmem_wen) begin
        assert (exp_st.size() != 0) else begin
          $display("dmem write seen after the model ran out of stores");
          errors++;
        end
        if (exp_st.size() != 0) begin
          want_st = exp_st.pop_front();
          check_word("o_dmem_addr", o_dmem_addr, want_st.addr);
          check_word("o_dmem_wdata", o_dmem_wdata, want_st.data);
        end
      end
      if (o_retire_valid) begin
        assert (exp_ret.size() != 0) else begin
          $display("an instruction retired after the model's program ended");
          errors++;
        end
        if (retired == 0) begin
          check_word("first o_retire_pc", o_retire_pc, `HART_RESET_ADDR);
        end
        if (exp_ret.size() != 0) begin
          want = exp_ret.pop_front();
          check_word("o_retire_pc", o_retire_pc, want.pc);
          check_word("o_retire_next_pc", o_retire_next_pc, want.next_pc);
          check_word("o_retire_inst", o_retire_inst, want.inst);
          check_word("o_retire_rd_waddr", o_retire_rd_waddr, want.rd);
          if (want.rd != '0) begin
            check_word("o_retire_rd_wdata", o_retire_rd_wdata, want.data);
          end
          check_word("o_retire_halt", o_retire_halt, want.halt);
        end
        retired++;
        done = (o_retire_halt === 1'b1);  // words past the ebreak are not part of the program
      end
    end
  end

  initial begin
    i_rst        = 1'b1;
    i_imem_rdata = '0;
    i_dmem_rdata = '0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = `HART_NOP_WORD;  // fetches past the program see harmless words
    end
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
    end
    gen_program();
    run_model();
    model_count = exp_ret.size();
    repeat (2) @(negedge i_clk);
    i_rst = 1'b0;
    while (!done && cycles < LIMIT) begin
      @(negedge i_clk);
    end
    if (!done) begin
      $display("timeout: the ebreak did not retire within %0d cycles", LIMIT);
      errors++;
    end
    check_word("retired count", retired, model_count);
    assert (exp_st.size() == 0) else begin
      $display("%0d stores expected by the model never reached dmem", exp_st.size());
      errors++;
    end
    $display("checks: %0d  errors: %0d  retired: %0d of %0d", checks, errors, retired,
             model_count);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* hart_core.f */
+incdir+logic
+incdir+testbench
logic/hart_pkg.sv
logic/hart_fetch.sv
logic/hart_decode.sv
logic/hart_regfile.sv
logic/hart_hazard.sv
logic/hart_execute.sv
logic/hart_memwb.sv
logic/hart_top.sv
testbench/hart_tb.sv
